// ==== counter_pkg.sv ====
/*
 * Shared widths and the wrap event record for the event-counting subsystem.
 * The epoch field truncates; after 256 loads it wraps without notice.
 */
`default_nettype none

package counter_pkg;

    // Datapath widths
    localparam int count_width = 16;
    localparam int epoch_width = 8;  // Loads accepted since reset, truncated
    localparam int total_width = 12; // Per-kind wrap totals, saturating

    // Which way the counter wrapped
    typedef enum logic {
        wrap_over  = 1'b0, // Up-count past the maximum
        wrap_under = 1'b1  // Down-count below zero
    } wrap_kind_t;

    // One wrap event as it travels counter -> FIFO -> tally
    typedef struct packed {
        wrap_kind_t              kind;
        logic [epoch_width-1:0]  epoch;
    } wrap_event_t;

endpackage

`default_nettype wire

// ==== updown_counter.sv ====
/*
 * Loadable 16-bit up/down counter, step of one, with one-cycle wrap pulses.
 * A load is only taken in idle; loads in count or wrap states are ignored.
 * push_event is valid only in the cycle push is high.
 */
`timescale 1ns/10ps
`default_nettype none

module updown_counter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                count_enable,
    input  logic                                count_direction, // 0 up, 1 down
    input  logic                                load_enable,
    input  logic [counter_pkg::count_width-1:0] load_value,
    output logic [counter_pkg::count_width-1:0] counter_value,
    output logic                                overflow,
    output logic                                underflow,
    output logic                                push,
    output counter_pkg::wrap_event_t            push_event
);

    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_count     = 2'd1,
        st_underflow = 2'd2,
        st_overflow  = 2'd3
    } state_t;

    localparam logic [counter_pkg::count_width-1:0] count_max = '1;

    state_t                                state;
    logic [counter_pkg::count_width-1:0]   count;
    logic [counter_pkg::epoch_width-1:0]   epoch;
    logic                                  wrap_now; // This edge wraps the count

    // A step at the boundary in the selected direction
    assign wrap_now = (state == st_count) && count_enable &&
                      (count_direction ? (count == '0) : (count == count_max));

    // Main state machine
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            count     <= '0;
            epoch     <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            overflow  <= 1'b0; // Pulses last one cycle
            underflow <= 1'b0;
            case (state)
                st_idle: begin
                    if (load_enable) begin
                        count <= load_value;
                        epoch <= epoch + 1'b1;
                    end else if (count_enable) begin
                        state <= st_count; // No step on the entry edge
                    end
                end
                st_count: begin
                    if (!count_enable) begin
                        state <= st_idle;
                    end else if (count_direction) begin
                        if (count == '0) begin
                            count     <= count_max;
                            underflow <= 1'b1;
                            state     <= st_underflow;
                        end else begin
                            count <= count - 1'b1;
                        end
                    end else begin
                        if (count == count_max) begin
                            count    <= '0;
                            overflow <= 1'b1;
                            state    <= st_overflow;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                st_overflow, st_underflow: begin
                    state <= st_idle; // Always one cycle in a wrap state
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Push strobe rises on the same edge as the wrap pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            push <= 1'b0;
        end else begin
            push <= wrap_now;
        end
    end

    // Event record, carries the epoch current at the wrap
    always_ff @(posedge clk) begin
        if (wrap_now) begin
            push_event.kind  <= count_direction ? counter_pkg::wrap_under
                                                : counter_pkg::wrap_over;
            push_event.epoch <= epoch;
        end
    end

    // Registered output lags the internal count by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counter_value <= '0;
        end else begin
            counter_value <= count;
        end
    end

    a_wrap_exclusive : assert property (
        @(posedge clk) disable iff (rst)
        !(overflow && underflow)
    ) else $error("overflow and underflow high together");

    // Push decode must agree with the pulses raised by the state machine
    a_push_matches_wrap : assert property (
        @(posedge clk) disable iff (rst)
        push == (overflow || underflow)
    ) else $error("push does not match the wrap pulses");

endmodule

`default_nettype wire

// ==== wrap_fifo.sv ====
/*
 * Synchronous FIFO of wrap events, fifo_depth a power of two, 2 or more.
 * A push while full is dropped, even if a pop happens on the same edge.
 * event_lost is sticky until reset. head is valid only while empty is 0.
 */
`timescale 1ns/10ps
`default_nettype none

module wrap_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push,
    input  counter_pkg::wrap_event_t  push_event,
    input  logic                      pop,
    output counter_pkg::wrap_event_t  head,
    output logic                      empty,
    output logic                      event_lost
);

    localparam int addr_width = $clog2(fifo_depth);

    counter_pkg::wrap_event_t  mem [fifo_depth];
    logic [addr_width:0]       wr_ptr; // Extra top bit tells full from empty
    logic [addr_width:0]       rd_ptr;
    logic                      full;
    logic                      write_ok;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_width] != rd_ptr[addr_width]) &&
                   (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);

    assign write_ok = push && !full;

    // Head read straight from storage, no extra latency
    assign head = mem[rd_ptr[addr_width-1:0]];

    // Storage
    always_ff @(posedge clk) begin
        if (write_ok) begin
            mem[wr_ptr[addr_width-1:0]] <= push_event;
        end
    end

    // Pointers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (write_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1; // Caller only pops when not empty
            end
        end
    end

    // Lost-event flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            event_lost <= 1'b0;
        end else if (push && full) begin
            event_lost <= 1'b1;
        end
    end

    // Guards the pop logic in the consumer
    a_no_pop_when_empty : assert property (
        @(posedge clk) disable iff (rst)
        pop |-> !empty
    ) else $error("pop while FIFO empty");

endmodule

`default_nettype wire

// ==== wrap_tally.sv ====
/*
 * Drains wrap events while drain is high, one per cycle.
 * Totals saturate at their maximum and hold there until reset.
 */
`timescale 1ns/10ps
`default_nettype none

module wrap_tally (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                drain,
    input  logic                                empty,
    input  counter_pkg::wrap_event_t            head,
    output logic                                pop,
    output logic [counter_pkg::total_width-1:0] overflow_total,
    output logic [counter_pkg::total_width-1:0] underflow_total,
    output logic [counter_pkg::epoch_width-1:0] last_epoch
);

    localparam logic [counter_pkg::total_width-1:0] total_max = '1;

    // Pop whenever allowed and something is waiting
    assign pop = drain && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            overflow_total  <= '0;
            underflow_total <= '0;
            last_epoch      <= '0;
        end else if (pop) begin
            last_epoch <= head.epoch;
            if (head.kind == counter_pkg::wrap_over) begin
                if (overflow_total != total_max) begin
                    overflow_total <= overflow_total + 1'b1;
                end
            end else begin
                if (underflow_total != total_max) begin
                    underflow_total <= underflow_total + 1'b1;
                end
            end
        end
    end

    // Totals only grow between resets
    a_totals_monotonic : assert property (
        @(posedge clk) disable iff (rst)
        (overflow_total >= $past(overflow_total)) &&
        (underflow_total >= $past(underflow_total))
    ) else $error("wrap total decreased without reset");

endmodule

`default_nettype wire

// ==== counter_subsys_top.sv ====
/*
 * Counter, wrap event FIFO and tally. drain is the only back-pressure;
 * the counter never waits and excess events are counted as lost.
 */
`timescale 1ns/10ps
`default_nettype none

module counter_subsys_top #(
    parameter int fifo_depth = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                count_enable,
    input  logic                                count_direction,
    input  logic                                load_enable,
    input  logic [counter_pkg::count_width-1:0] load_value,
    input  logic                                drain,
    output logic [counter_pkg::count_width-1:0] counter_value,
    output logic                                overflow,
    output logic                                underflow,
    output logic [counter_pkg::total_width-1:0] overflow_total,
    output logic [counter_pkg::total_width-1:0] underflow_total,
    output logic [counter_pkg::epoch_width-1:0] last_epoch,
    output logic                                event_lost
);

    logic                      push;
    counter_pkg::wrap_event_t  push_event;
    logic                      pop;
    logic                      empty;
    counter_pkg::wrap_event_t  head;

    updown_counter u_counter (
        .clk             (clk),
        .rst             (rst),
        .count_enable    (count_enable),
        .count_direction (count_direction),
        .load_enable     (load_enable),
        .load_value      (load_value),
        .counter_value   (counter_value),
        .overflow        (overflow),
        .underflow       (underflow),
        .push            (push),
        .push_event      (push_event)
    );

    wrap_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_event (push_event),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .event_lost (event_lost)
    );

    wrap_tally u_tally (
        .clk             (clk),
        .rst             (rst),
        .drain           (drain),
        .empty           (empty),
        .head            (head),
        .pop             (pop),
        .overflow_total  (overflow_total),
        .underflow_total (underflow_total),
        .last_epoch      (last_epoch)
    );

endmodule

`default_nettype wire

// ==== tb_counter_subsys.sv ====
/*
 * Table-driven testbench for counter_subsys_top, fifo_depth 4.
 * A cycle-level model predicts every output; checks run on each falling edge.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_counter_subsys;

    localparam int fifo_depth = 4;
    localparam int cw = counter_pkg::count_width;
    localparam int ew = counter_pkg::epoch_width;
    localparam int tw = counter_pkg::total_width;

    // Model states, both wrap states behave alike
    localparam int ms_idle  = 0;
    localparam int ms_count = 1;
    localparam int ms_wrap  = 2;

    typedef struct packed {
        logic [3:0]    test;
        logic          rst;
        logic          load_enable;
        logic [cw-1:0] load_value;
        logic          use_random;
        logic          count_enable;
        logic          count_direction;
        logic          drain;
        logic [7:0]    cycles;
    } stim_row_t;

    logic          clk = 1'b0;
    logic          rst;
    logic          count_enable;
    logic          count_direction;
    logic          load_enable;
    logic [cw-1:0] load_value;
    logic          drain;
    logic [cw-1:0] counter_value;
    logic          overflow;
    logic          underflow;
    logic [tw-1:0] overflow_total;
    logic [tw-1:0] underflow_total;
    logic [ew-1:0] last_epoch;
    logic          event_lost;

    stim_row_t     rows[$];
    string         test_names[7];
    integer        seed;
    logic          checking = 1'b0;
    int            pass_count = 0;
    int            fail_count = 0;
    int            cycle_count = 0;
    int            cycle_limit = 100000;

    // Reference model state
    int            m_state;
    logic [cw-1:0] m_count;
    logic [cw-1:0] m_value;
    logic [ew-1:0] m_epoch;
    logic          m_ovf;
    logic          m_unf;
    logic          m_push;
    logic [ew:0]   m_push_ev;  // Kind on top, 1 for underflow
    logic [ew:0]   m_fifo[$];
    logic          m_lost;
    logic [tw-1:0] m_ovf_total;
    logic [tw-1:0] m_unf_total;
    logic [ew-1:0] m_last_epoch;

    counter_subsys_top #(
        .fifo_depth (fifo_depth)
    ) u_dut (
        .clk             (clk),
        .rst             (rst),
        .count_enable    (count_enable),
        .count_direction (count_direction),
        .load_enable     (load_enable),
        .load_value      (load_value),
        .drain           (drain),
        .counter_value   (counter_value),
        .overflow        (overflow),
        .underflow       (underflow),
        .overflow_total  (overflow_total),
        .underflow_total (underflow_total),
        .last_epoch      (last_epoch),
        .event_lost      (event_lost)
    );

    always #5 clk = ~clk;

    function automatic logic [tw-1:0] saturating_increment(input logic [tw-1:0] total);
        if (total == '1) begin
            return total;
        end
        return total + 1'b1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic add_row(input int test, input int rst_bit, input int ld, input int value,
                           input int rnd, input int en, input int dir, input int drn,
                           input int cycles);
        stim_row_t r;
        r.test            = 4'(test);
        r.rst             = 1'(rst_bit);
        r.load_enable     = 1'(ld);
        r.load_value      = cw'(value);
        r.use_random      = 1'(rnd);
        r.count_enable    = 1'(en);
        r.count_direction = 1'(dir);
        r.drain           = 1'(drn);
        r.cycles          = 8'(cycles);
        rows.push_back(r);
    endtask

    // Columns: test, rst, load, value, random, enable, direction, drain, cycles
    task automatic build_table();
        add_row(1, 0, 1, 100, 0, 0, 0, 1, 1);
        add_row(1, 0, 0, 0, 0, 1, 0, 1, 20);
        add_row(1, 0, 0, 0, 0, 0, 0, 1, 2);
        add_row(2, 0, 1, 65533, 0, 0, 0, 1, 1);
        add_row(2, 0, 0, 0, 0, 1, 0, 1, 8);  // Wraps once, then counts again
        add_row(2, 0, 0, 0, 0, 0, 0, 1, 3);
        add_row(3, 0, 1, 1, 0, 0, 0, 1, 1);
        add_row(3, 0, 0, 0, 0, 1, 1, 1, 6);
        add_row(3, 0, 0, 0, 0, 0, 0, 1, 3);
        add_row(4, 0, 1, 0, 1, 0, 0, 1, 1);  // Random start value
        add_row(4, 0, 0, 0, 0, 1, 0, 1, 5);
        add_row(4, 0, 0, 0, 0, 0, 0, 1, 2);
        add_row(4, 0, 0, 0, 0, 1, 0, 1, 5);
        add_row(4, 0, 0, 0, 0, 0, 0, 1, 1);
        add_row(4, 0, 0, 0, 0, 1, 1, 1, 4);
        add_row(4, 0, 0, 0, 0, 0, 0, 1, 2);
        // Five wraps into a full FIFO, drain held low
        add_row(5, 0, 1, 65535, 0, 0, 0, 0, 1);
        add_row(5, 0, 0, 0, 0, 1, 0, 0, 3);
        add_row(5, 0, 1, 0, 0, 0, 0, 0, 1);
        add_row(5, 0, 0, 0, 0, 1, 1, 0, 3);
        add_row(5, 0, 1, 65535, 0, 0, 0, 0, 1);
        add_row(5, 0, 0, 0, 0, 1, 0, 0, 3);
        add_row(5, 0, 1, 65535, 0, 0, 0, 0, 1);
        add_row(5, 0, 0, 0, 0, 1, 0, 0, 3);
        add_row(5, 0, 1, 0, 0, 0, 0, 0, 1);
        add_row(5, 0, 0, 0, 0, 1, 1, 0, 3);
        add_row(5, 0, 0, 0, 0, 0, 0, 1, 6);
        add_row(6, 1, 0, 0, 0, 0, 0, 0, 3);
        add_row(6, 0, 1, 65535, 0, 0, 0, 1, 1);
        add_row(6, 0, 0, 0, 0, 1, 0, 1, 2);
        add_row(6, 0, 1, 7, 0, 0, 0, 1, 1);  // Lands in the wrap state
        add_row(6, 0, 1, 9, 0, 0, 0, 1, 1);
        add_row(6, 0, 0, 0, 0, 0, 0, 1, 3);
    endtask

    // Model steps on the same edges as the DUT, inputs seen before the edge
    always @(posedge clk or posedge rst) begin : ref_model
        logic        full_before;
        logic [ew:0] front;
        if (rst) begin
            m_state      = ms_idle;
            m_count      = '0;
            m_value      = '0;
            m_epoch      = '0;
            m_ovf        = 1'b0;
            m_unf        = 1'b0;
            m_push       = 1'b0;
            m_push_ev    = '0;
            m_lost       = 1'b0;
            m_ovf_total  = '0;
            m_unf_total  = '0;
            m_last_epoch = '0;
            m_fifo.delete();
        end else begin
            full_before = (m_fifo.size() == fifo_depth);
            if (drain && m_fifo.size() != 0) begin
                front = m_fifo.pop_front();
                m_last_epoch = front[ew-1:0];
                if (front[ew] == 1'b0) begin
                    m_ovf_total = saturating_increment(m_ovf_total);
                end else begin
                    m_unf_total = saturating_increment(m_unf_total);
                end
            end
            if (m_push) begin  // Raised one edge earlier, stored now
                if (full_before) begin
                    m_lost = 1'b1;
                end else begin
                    m_fifo.push_back(m_push_ev);
                end
            end
            m_value = m_count;
            m_ovf   = 1'b0;
            m_unf   = 1'b0;
            m_push  = 1'b0;
            case (m_state)
                ms_idle: begin
                    if (load_enable) begin
                        m_count = load_value;
                        m_epoch = m_epoch + 1'b1;
                    end else if (count_enable) begin
                        m_state = ms_count;
                    end
                end
                ms_count: begin
                    if (!count_enable) begin
                        m_state = ms_idle;
                    end else if (!count_direction && m_count == '1) begin
                        m_count   = '0;
                        m_ovf     = 1'b1;
                        m_push    = 1'b1;
                        m_push_ev = {1'b0, m_epoch};
                        m_state   = ms_wrap;
                    end else if (count_direction && m_count == '0) begin
                        m_count   = '1;
                        m_unf     = 1'b1;
                        m_push    = 1'b1;
                        m_push_ev = {1'b1, m_epoch};
                        m_state   = ms_wrap;
                    end else if (count_direction) begin
                        m_count = m_count - 1'b1;
                    end else begin
                        m_count = m_count + 1'b1;
                    end
                end
                default: m_state = ms_idle;
            endcase
        end
    end

    // While rst is high every output must read zero
    always @(negedge clk) begin
        if (checking) begin
            check_value("counter_value", 32'(counter_value), rst ? 32'd0 : 32'(m_value));
            check_value("overflow", 32'(overflow), rst ? 32'd0 : 32'(m_ovf));
            check_value("underflow", 32'(underflow), rst ? 32'd0 : 32'(m_unf));
            check_value("overflow_total", 32'(overflow_total), rst ? 32'd0 : 32'(m_ovf_total));
            check_value("underflow_total", 32'(underflow_total),
                        rst ? 32'd0 : 32'(m_unf_total));
            check_value("last_epoch", 32'(last_epoch), rst ? 32'd0 : 32'(m_last_epoch));
            check_value("event_lost", 32'(event_lost), rst ? 32'd0 : 32'(m_lost));
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run went past %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin : stimulus
        stim_row_t     row;
        int            limit;
        int            test_fails;
        int            rand_word;
        logic [cw-1:0] value;
        seed            = 88572;
        rst             = 1'b1;
        count_enable    = 1'b0;
        count_direction = 1'b0;
        load_enable     = 1'b0;
        load_value      = '0;
        drain           = 1'b0;
        test_names[0] = "unused";
        test_names[1] = "load and count up";
        test_names[2] = "overflow";
        test_names[3] = "underflow";
        test_names[4] = "enable gaps";
        test_names[5] = "back-pressure";
        test_names[6] = "reset state";
        build_table();
        limit = 200;
        foreach (rows[i]) begin
            limit += int'(rows[i].cycles);
        end
        cycle_limit = limit + 10;  // Reset cycles on top
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        checking = 1'b1;
        test_fails = 0;
        for (int i = 0; i < rows.size(); i++) begin
            row   = rows[i];
            value = row.load_value;
            if (row.use_random) begin
                rand_word = $random(seed);
                value     = rand_word[cw-1:0];
            end
            repeat (row.cycles) begin
                @(posedge clk);
                rst             <= row.rst;
                load_enable     <= row.load_enable;
                load_value      <= value;
                count_enable    <= row.count_enable;
                count_direction <= row.count_direction;
                drain           <= row.drain;
            end
            if (i == rows.size() - 1 || rows[i+1].test != row.test) begin
                @(negedge clk);
                #1;
                $display("Test %0d (%s) finished, %0d mismatches", row.test,
                         test_names[row.test], fail_count - test_fails);
                test_fails = fail_count;
            end
        end
        @(posedge clk);
        @(negedge clk);
        #1;
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
counter_pkg.sv
updown_counter.sv
wrap_fifo.sv
wrap_tally.sv
counter_subsys_top.sv
tb_counter_subsys.sv

// ==== Makefile ====
# Verilator build and run of the counter subsystem testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_counter_subsys
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
